// File: source/mult_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map and bit positions of the APB multiplier peripheral
// offsets are byte addresses on an 8-bit APB address bus
// operand width is a parameter of the top level, from 4 to 16 bits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mult_pkg;

    // bus widths
    localparam int addr_w  = 8;
    localparam int data_w  = 32;

    // extra accumulator bits above the full product
    localparam int guard_w = 8;

    // register offsets
    localparam logic [addr_w-1:0] reg_ctrl   = 'h00;
    localparam logic [addr_w-1:0] reg_opa    = 'h04;
    localparam logic [addr_w-1:0] reg_opb    = 'h08;
    localparam logic [addr_w-1:0] reg_res_lo = 'h0C;
    localparam logic [addr_w-1:0] reg_res_hi = 'h10;
    localparam logic [addr_w-1:0] reg_status = 'h14;

    // control word, start and clear are write-one pulses
    localparam int ctrl_start    = 0;
    localparam int ctrl_unsigned = 1;
    localparam int ctrl_acc      = 2;
    localparam int ctrl_clear    = 3;

    // status word, done is sticky until the next start
    localparam int st_busy = 0;
    localparam int st_done = 1;

endpackage

// File: source/apb_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave signals without pstrb and pprot
// the slave keeps pready high, so every access cycle completes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface apb_bus_if;

    import mult_pkg::*;

    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

endinterface

// File: source/mult_req_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// job request and result between register block and engine
// start and clear are one-cycle pulses, operands stay stable until done
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface mult_req_if #(parameter int WIDTH = 16);

    import mult_pkg::*;

    logic                       start;
    logic                       clear;
    logic                       unsigned_mode;
    logic                       acc_mode;
    logic [WIDTH-1:0]           op_a;
    logic [WIDTH-1:0]           op_b;
    logic                       busy;
    logic                       done;
    logic [2*WIDTH+guard_w-1:0] acc_value;

    modport regs (
        output start, clear, unsigned_mode, acc_mode, op_a, op_b,
        input  busy, done, acc_value
    );

    modport engine (
        input  start, clear, unsigned_mode, acc_mode, op_a, op_b,
        output busy, done, acc_value
    );

endinterface

// File: source/bw_array_mult.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational Baugh-Wooley carry-save array multiplier
// signed two's complement by default, unsigned when unsigned_mode is set
// product is the full 2*WIDTH result, WIDTH must be at least 2
// one long ripple path through the last row, so keep WIDTH modest
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bw_array_mult #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    input  logic               unsigned_mode,
    output logic [2*WIDTH-1:0] product
);

    logic             signed_mode;

    // pp[i][j] = a[j] & b[i], weight 2**(i+j)
    logic [WIDTH-1:0] pp [WIDTH];

    // s[i][j] sits at column i+j, c[i][j] carries into column i+j+1
    logic [WIDTH-1:0] s  [WIDTH];
    logic [WIDTH-1:0] c  [1:WIDTH-1];

    // carry chain of the final row
    logic [WIDTH-1:0] rc;

    assign signed_mode = ~unsigned_mode;

    // partial products, sign row and sign column inverted in signed mode
    for (genvar i = 0; i < WIDTH; i++) begin : g_pp_row
        for (genvar j = 0; j < WIDTH; j++) begin : g_pp_col
            localparam bit edge_term = (i == WIDTH - 1) ^ (j == WIDTH - 1);
            assign pp[i][j] = (a[j] & b[i]) ^ (edge_term & signed_mode);
        end
    end

    assign s[0] = pp[0];

    // carry-save rows
    for (genvar i = 1; i < WIDTH; i++) begin : g_row
        for (genvar j = 0; j < WIDTH; j++) begin : g_cell
            if (i == 1 && j == WIDTH - 1) begin : g_pass
                // nothing above yet, the bit drops straight down
                assign s[i][j] = pp[i][j];
                assign c[i][j] = 1'b0;
            end else if (j == WIDTH - 1) begin : g_ha_left
                // leftmost cell, half adder on pp and carry
                assign s[i][j] = pp[i][j] ^ c[i-1][j];
                assign c[i][j] = pp[i][j] & c[i-1][j];
            end else if (i == 1) begin : g_ha_first
                // first adder row has no carries in
                assign s[i][j] = pp[i][j] ^ s[i-1][j+1];
                assign c[i][j] = pp[i][j] & s[i-1][j+1];
            end else begin : g_fa
                assign s[i][j] = pp[i][j] ^ s[i-1][j+1] ^ c[i-1][j];
                assign c[i][j] = (pp[i][j] & s[i-1][j+1])
                               | (pp[i][j] & c[i-1][j])
                               | (s[i-1][j+1] & c[i-1][j]);
            end
        end
    end

    // low half leaves the array one bit per row
    for (genvar i = 0; i < WIDTH; i++) begin : g_low
        assign product[i] = s[i][0];
    end

    // correction one at column WIDTH enters as the ripple carry-in
    assign rc[0] = signed_mode;

    // final ripple row over columns WIDTH .. 2*WIDTH-1
    for (genvar j = 0; j < WIDTH; j++) begin : g_ripple
        if (j < WIDTH - 1) begin : g_mid
            assign product[WIDTH+j] = s[WIDTH-1][j+1] ^ c[WIDTH-1][j] ^ rc[j];
            assign rc[j+1] = (s[WIDTH-1][j+1] & c[WIDTH-1][j])
                           | (s[WIDTH-1][j+1] & rc[j])
                           | (c[WIDTH-1][j] & rc[j]);
        end else begin : g_top
            // top column takes the second correction one in signed mode,
            // in unsigned mode it only carries, and the carry out is dropped
            assign product[WIDTH+j] = signed_mode ^ c[WIDTH-1][j] ^ rc[j];
        end
    end

endmodule

// File: source/mult_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-job multiply engine around the Baugh-Wooley array
// a job takes two edges: capture at start, accumulate and done one later
// start must not arrive while busy, there is no queue
// clear is ignored while a job is running
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mult_engine #(
    parameter int WIDTH = 16
) (
    input logic      clk,
    input logic      arst_n,
    mult_req_if.engine req
);

    import mult_pkg::*;

    localparam int acc_w = 2 * WIDTH + guard_w;

    logic [WIDTH-1:0]   a_q;
    logic [WIDTH-1:0]   b_q;
    logic               unsigned_q;
    logic               acc_mode_q;
    logic               busy;
    logic               done;
    logic [2*WIDTH-1:0] product;
    logic [acc_w-1:0]   prod_ext;
    logic [acc_w-1:0]   acc;

    bw_array_mult #(
        .WIDTH(WIDTH)
    ) u_array (
        .a            (a_q),
        .b            (b_q),
        .unsigned_mode(unsigned_q),
        .product      (product)
    );

    // widen the product to the guarded accumulator
    always_comb begin
        if (unsigned_q) begin
            prod_ext = {{guard_w{1'b0}}, product};
        end else begin
            prod_ext = {{guard_w{product[2*WIDTH-1]}}, product};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q        <= '0;
            b_q        <= '0;
            unsigned_q <= 1'b0;
            acc_mode_q <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            acc        <= '0;
        end else begin
            done <= 1'b0;
            if (req.start && !busy) begin
                a_q        <= req.op_a;
                b_q        <= req.op_b;
                unsigned_q <= req.unsigned_mode;
                acc_mode_q <= req.acc_mode;
                busy       <= 1'b1;
            end else if (busy) begin
                // array output has settled from the captured operands
                acc  <= acc_mode_q ? acc + prod_ext : prod_ext;
                busy <= 1'b0;
                done <= 1'b1;
            end else if (req.clear) begin
                acc <= '0;
            end
        end
    end

    assign req.busy      = busy;
    assign req.done      = done;
    assign req.acc_value = acc;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        req.start |-> !busy);

    // operands from the register block stay put while a job runs
    a_ops_stable: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> (req.op_a == $past(req.op_a)) && (req.op_b == $past(req.op_b)));

endmodule

// File: source/mult_apb_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register file of the multiplier, no wait states, no byte strobes
// writes to ctrl, opa or opb while a job runs fail with pslverr
// unmapped offsets and writes to read-only registers fail with pslverr
// result words are the accumulator, sign-extended in signed mode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mult_apb_regs #(
    parameter int WIDTH = 16
) (
    input logic      clk,
    input logic      arst_n,
    apb_bus_if.slave bus,
    mult_req_if.regs req
);

    import mult_pkg::*;

    localparam int acc_w = 2 * WIDTH + guard_w;

    logic [WIDTH-1:0]    op_a;
    logic [WIDTH-1:0]    op_b;
    logic                unsigned_mode;
    logic                acc_mode;
    logic                start;
    logic                clear;
    logic                done_flag;
    logic                busy_any;
    logic                access;
    logic                wr_en;
    logic                rd_en;
    logic                err;
    logic [data_w-1:0]   rd_data;
    logic [2*data_w-1:0] res_wide;

    assign access = bus.psel & bus.penable;
    assign wr_en  = access & bus.pwrite;
    assign rd_en  = access & ~bus.pwrite;

    // a start still in flight to the engine counts as busy
    assign busy_any = req.busy | start;

    assign res_wide = unsigned_mode ?
        {{(2*data_w-acc_w){1'b0}}, req.acc_value} :
        {{(2*data_w-acc_w){req.acc_value[acc_w-1]}}, req.acc_value};

    // read mux and error decode
    always_comb begin
        rd_data = '0;
        err     = 1'b0;
        case (bus.paddr)
            reg_ctrl: begin
                rd_data[ctrl_unsigned] = unsigned_mode;
                rd_data[ctrl_acc]      = acc_mode;
                err                    = bus.pwrite & busy_any;
            end
            reg_opa: begin
                rd_data[WIDTH-1:0] = op_a;
                err                = bus.pwrite & busy_any;
            end
            reg_opb: begin
                rd_data[WIDTH-1:0] = op_b;
                err                = bus.pwrite & busy_any;
            end
            reg_res_lo: begin
                rd_data = res_wide[data_w-1:0];
                err     = bus.pwrite;
            end
            reg_res_hi: begin
                rd_data = res_wide[2*data_w-1:data_w];
                err     = bus.pwrite;
            end
            reg_status: begin
                rd_data[st_busy] = busy_any;
                rd_data[st_done] = done_flag;
                err              = bus.pwrite;
            end
            default: err = 1'b1;
        endcase
    end

    assign bus.prdata  = (rd_en && !err) ? rd_data : '0;
    assign bus.pready  = 1'b1;
    assign bus.pslverr = access & err;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_a          <= '0;
            op_b          <= '0;
            unsigned_mode <= 1'b0;
            acc_mode      <= 1'b0;
            start         <= 1'b0;
            clear         <= 1'b0;
            done_flag     <= 1'b0;
        end else begin
            start <= 1'b0;
            clear <= 1'b0;
            if (wr_en && !err) begin
                case (bus.paddr)
                    reg_ctrl: begin
                        unsigned_mode <= bus.pwdata[ctrl_unsigned];
                        acc_mode      <= bus.pwdata[ctrl_acc];
                        start         <= bus.pwdata[ctrl_start];
                        clear         <= bus.pwdata[ctrl_clear];
                    end
                    reg_opa: op_a <= bus.pwdata[WIDTH-1:0];
                    reg_opb: op_b <= bus.pwdata[WIDTH-1:0];
                    default: ;
                endcase
            end
            // sticky done, dropped by the next start
            if (start) begin
                done_flag <= 1'b0;
            end else if (req.done) begin
                done_flag <= 1'b1;
            end
        end
    end

    assign req.start         = start;
    assign req.clear         = clear;
    assign req.unsigned_mode = unsigned_mode;
    assign req.acc_mode      = acc_mode;
    assign req.op_a          = op_a;
    assign req.op_b          = op_b;

    a_apb_setup: assert property (@(posedge clk) disable iff (!arst_n)
        bus.penable |-> bus.psel && $past(bus.psel));

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !req.busy);

endmodule

// File: source/apb_mult_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB multiplier peripheral, register block plus one-job engine
// WIDTH from 4 to 16, so that one operand fits one data word
// no interrupt, software polls the status register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module apb_mult_top #(
    parameter int WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [mult_pkg::addr_w-1:0] paddr,
    input  logic [mult_pkg::data_w-1:0] pwdata,
    output logic [mult_pkg::data_w-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr
);

    if (WIDTH < 4 || WIDTH > 16) begin : g_width_check
        $error("apb_mult_top: WIDTH must be in 4..16");
    end

    apb_bus_if bus_if ();
    mult_req_if #(.WIDTH(WIDTH)) req_if ();

    assign bus_if.psel    = psel;
    assign bus_if.penable = penable;
    assign bus_if.pwrite  = pwrite;
    assign bus_if.paddr   = paddr;
    assign bus_if.pwdata  = pwdata;
    assign prdata         = bus_if.prdata;
    assign pready         = bus_if.pready;
    assign pslverr        = bus_if.pslverr;

    mult_apb_regs #(.WIDTH(WIDTH)) u_regs (
        .clk   (clk),
        .arst_n(arst_n),
        .bus   (bus_if.slave),
        .req   (req_if.regs)
    );

    mult_engine #(.WIDTH(WIDTH)) u_engine (
        .clk   (clk),
        .arst_n(arst_n),
        .req   (req_if.engine)
    );

endmodule

// File: test/tb_mult_tasks.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB host tasks and reference model, included inside tb_apb_mult
// tasks are entered a short delay after a rising edge and return the same way
// a call right after another one gives a back-to-back transfer
// bus and poll timeouts count as errors and return without data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic apb_transfer(
    input  logic              wr,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    output logic              err
);
    int cycles;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #drive_dly;
    penable = 1'b1;
    cycles  = 0;
    rdata   = '0;
    err     = 1'b1;
    // access phase, outputs sampled mid-cycle
    @(negedge clk);
    while (!pready && cycles < bus_timeout) begin
        cycles++;
        @(negedge clk);
    end
    if (pready) begin
        rdata = prdata;
        err   = pslverr;
    end else begin
        $display("%0t: no pready from the DUT at offset %h", $time, addr);
        err_count++;
    end
    @(posedge clk);
    #drive_dly;
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                         output logic err);
    logic [data_w-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
endtask

task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                        output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
endtask

// poll status until the sticky done bit shows up
task automatic wait_done(output logic ok);
    logic [data_w-1:0] st;
    logic              err;
    int                polls;
    ok    = 1'b0;
    polls = 0;
    while (!ok && polls < poll_timeout) begin
        apb_read(reg_status, st, err);
        ok = st[st_done];
        polls++;
    end
    if (!ok) begin
        $display("%0t: done bit never set after %0d status polls", $time, polls);
        err_count++;
    end
endtask

// full-width product, sign- or zero-extended to the accumulator width
function automatic logic [acc_w-1:0] model_product(input logic [width-1:0] a,
                                                   input logic [width-1:0] b,
                                                   input logic uns);
    logic [acc_w-1:0] ext_a;
    logic [acc_w-1:0] ext_b;
    ext_a = {{(acc_w-width){a[width-1] & ~uns}}, a};
    ext_b = {{(acc_w-width){b[width-1] & ~uns}}, b};
    return ext_a * ext_b;
endfunction

// upper result word, the guard bits extended to a full word
function automatic logic [data_w-1:0] expected_hi(input logic [acc_w-1:0] acc,
                                                  input logic uns);
    logic [data_w-1:0] hi;
    hi = uns ? {data_w{1'b0}} : {data_w{acc[acc_w-1]}};
    hi[acc_w-data_w-1:0] = acc[acc_w-1:data_w];
    return hi;
endfunction

// File: test/tb_apb_mult.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for apb_mult_top with WIDTH 16
// random operands from a fixed seed, checked against a model accumulator
// needs a simulator with timing support for the delays
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_apb_mult;

    import mult_pkg::*;

    localparam int width        = 16;
    localparam int acc_w        = 2 * width + guard_w;
    localparam int half_period  = 10;
    localparam int drive_dly    = 2;
    localparam int bus_timeout  = 16;
    localparam int poll_timeout = 50;

    logic              clk;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;

    integer            seed;
    int                err_count;
    int                test_count;
    int                test_start;
    logic [acc_w-1:0]  model_acc;

    apb_mult_top #(.WIDTH(width)) uut (
        .clk    (clk),
        .arst_n (arst_n),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

    `include "tb_mult_tasks.svh"

    task automatic check_word(input string what, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s read %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic write_ok(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        logic err;
        apb_write(addr, data, err);
        if (err) begin
            $display("%0t: unexpected pslverr on write to offset %h", $time, addr);
            err_count++;
        end
    endtask

    task automatic read_ok(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
        logic err;
        apb_read(addr, data, err);
        if (err) begin
            $display("%0t: unexpected pslverr on read of offset %h", $time, addr);
            err_count++;
        end
    endtask

    task automatic write_ctrl(input logic start, input logic uns, input logic acc,
                              input logic clear);
        logic [data_w-1:0] ctrl;
        ctrl                = '0;
        ctrl[ctrl_start]    = start;
        ctrl[ctrl_unsigned] = uns;
        ctrl[ctrl_acc]      = acc;
        ctrl[ctrl_clear]    = clear;
        write_ok(reg_ctrl, ctrl);
    endtask

    // wait for the job, then compare both result words with the model
    task automatic check_result(input string label, input logic uns);
        logic              ok;
        logic [data_w-1:0] lo;
        logic [data_w-1:0] hi;
        wait_done(ok);
        if (ok) begin
            read_ok(reg_res_lo, lo);
            check_word({label, " res_lo"}, lo, model_acc[data_w-1:0]);
            read_ok(reg_res_hi, hi);
            check_word({label, " res_hi"}, hi, expected_hi(model_acc, uns));
        end
    endtask

    task automatic run_job(input logic [width-1:0] a, input logic [width-1:0] b,
                           input logic uns, input logic acc);
        write_ok(reg_opa, {{(data_w-width){1'b0}}, a});
        write_ok(reg_opb, {{(data_w-width){1'b0}}, b});
        write_ctrl(1'b1, uns, acc, 1'b0);
        model_acc = acc ? model_acc + model_product(a, b, uns) : model_product(a, b, uns);
        check_result($sformatf("%h*%h", a, b), uns);
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, err_count - test_start);
        test_count++;
        test_start = err_count;
    endtask

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        logic [31:0]      rnd;
        logic [data_w-1:0] rd;
        logic             err;
        logic [width-1:0] min_neg;
        logic [width-1:0] max_pos;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        seed       = 32'hbf9c;
        err_count  = 0;
        test_count = 0;
        test_start = 0;
        model_acc  = '0;
        min_neg    = {1'b1, {(width-1){1'b0}}};
        max_pos    = {1'b0, {(width-1){1'b1}}};
        repeat (4) @(posedge clk);
        #drive_dly;
        arst_n = 1'b1;

        read_ok(reg_status, rd);
        check_word("status after reset", rd, '0);
        read_ok(reg_res_lo, rd);
        check_word("res_lo after reset", rd, '0);
        read_ok(reg_res_hi, rd);
        check_word("res_hi after reset", rd, '0);
        end_test("reset");

        for (int u = 0; u < 2; u++) begin
            for (int n = 0; n < 200; n++) begin
                rnd = $random(seed);
                run_job(rnd[width-1:0], rnd[data_w-1:data_w-width], u[0], 1'b0);
            end
            end_test(u == 0 ? "signed_random" : "unsigned_random");
        end

        // corner operands in both modes
        for (int u = 0; u < 2; u++) begin
            rnd = $random(seed);
            run_job(min_neg, min_neg, u[0], 1'b0);
            run_job(min_neg, '1, u[0], 1'b0);
            run_job(max_pos, max_pos, u[0], 1'b0);
            run_job('0, rnd[width-1:0], u[0], 1'b0);
            run_job('1, '1, u[0], 1'b0);
        end
        end_test("corners");

        write_ctrl(1'b0, 1'b0, 1'b1, 1'b1);
        model_acc = '0;
        for (int n = 0; n < 20; n++) begin
            rnd = $random(seed);
            run_job(rnd[width-1:0], rnd[data_w-1:data_w-width], 1'b0, 1'b1);
        end
        end_test("accumulate");

        // opa write lands back-to-back with the start, while the job runs
        rnd = $random(seed);
        write_ok(reg_opa, {{(data_w-width){1'b0}}, rnd[width-1:0]});
        write_ok(reg_opb, {{(data_w-width){1'b0}}, rnd[data_w-1:data_w-width]});
        write_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
        apb_write(reg_opa, {{(data_w-width){1'b0}}, ~rnd[width-1:0]}, err);
        if (!err) begin
            $display("%0t: write to opa during a job was not rejected", $time);
            err_count++;
        end
        model_acc = model_product(rnd[width-1:0], rnd[data_w-1:data_w-width], 1'b0);
        check_result("busy job", 1'b0);
        write_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
        check_result("job after rejected write", 1'b0);
        apb_read(8'h1C, rd, err);
        if (!err) begin
            $display("%0t: read of unmapped offset 1C gave no pslverr", $time);
            err_count++;
        end
        check_word("unmapped offset 1C", rd, '0);
        apb_write(reg_res_lo, 32'h1234_5678, err);
        if (!err) begin
            $display("%0t: write to read-only res_lo gave no pslverr", $time);
            err_count++;
        end
        end_test("errors");

        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: apb_mult.f
+incdir+test
source/mult_pkg.sv
source/apb_bus_if.sv
source/mult_req_if.sv
source/bw_array_mult.sv
source/mult_engine.sv
source/mult_apb_regs.sv
source/apb_mult_top.sv
test/tb_apb_mult.sv

// File: run_sim.sh
#!/bin/sh
# compile and run tb_apb_mult with Verilator, status 0 only on a passing run

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_apb_mult -f apb_mult.f -o tb_apb_mult
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_apb_mult > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log"; then
    exit 0
fi
exit 1
